//--- design/core_pkg.sv
package core_pkg;

	// ------------------------------------------------------------
	// front-end scalar types

	// word address, byte offset already dropped
	typedef logic [37:0] pc38_t;

	// indirect branch global history, kept outside the IBTB
	typedef logic [7:0] ibtb_gh_t;

	// address space id of the fetching context
	typedef logic [8:0] asid_t;

	// ------------------------------------------------------------
	// IBTB request and response bundles

	// lookup, presented every cycle
	typedef struct packed {
		pc38_t    src_pc;
		ibtb_gh_t gh;
		asid_t    asid;
	} ibtb_lookup_t;

	// training update, qualified by valid
	typedef struct packed {
		logic     valid;
		pc38_t    src_pc;
		ibtb_gh_t gh;
		asid_t    asid;
		pc38_t    tgt_pc;
	} ibtb_update_t;

	// prediction back to fetch
	typedef struct packed {
		logic  hit;
		pc38_t tgt_pc;
	} ibtb_result_t;

endpackage

//--- design/ibtb_pkg.sv
package ibtb_pkg;

	import core_pkg::*;

	// ------------------------------------------------------------
	// sizing constants

	// stored tag width
	localparam int TAG_BITS = 10;

	// widest set index, 256 sets
	localparam int MAX_INDEX_BITS = 8;

	// ------------------------------------------------------------
	// storage types

	typedef logic [TAG_BITS-1:0] ibtb_tag_t;

	// one direct-mapped entry
	// tag is the hashed tag, not raw pc bits
	typedef struct packed {
		logic      valid;
		ibtb_tag_t tag;
		pc38_t     tgt_pc;
	} ibtb_entry_t;

	// ------------------------------------------------------------
	// hashed address

	// set index and tag derived from pc, history and asid
	// index held at full width, narrowed by the user to log2(SETS)
	typedef struct packed {
		logic [MAX_INDEX_BITS-1:0] index;
		ibtb_tag_t                 tag;
	} ibtb_hashed_t;

endpackage

//--- design/ibtb_hash.sv
`timescale 1ns/1ps

module ibtb_hash
	import core_pkg::*, ibtb_pkg::*;
#(
	parameter int SETS = 64,
	localparam int IDX_BITS = $clog2(SETS)
) (
	input logic CLK,
	input logic nRST,

	// requests from fetch
	input ibtb_lookup_t lookup,
	input ibtb_update_t update,

	// read side, to array and resolve
	output logic [IDX_BITS-1:0] rd_index,
	output ibtb_tag_t rd_tag,
	output pc38_t rd_src_pc,

	// write side, to array
	output logic wr_en,
	output logic [IDX_BITS-1:0] wr_index,
	output ibtb_entry_t wr_entry
);

	// ------------------------------------------------------------
	// request registers

	ibtb_lookup_t lookup_q;
	ibtb_update_t update_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lookup_q <= '0;
			update_q <= '0;
		end else begin
			lookup_q <= lookup;
			update_q <= update;
		end
	end

	// ------------------------------------------------------------
	// hash

	// index: low pc bits ^ history ^ asid, all at index width
	// tag: pc bits above the index ^ asid ^ history, at tag width
	function automatic ibtb_hashed_t hash_addr(input pc38_t pc, input ibtb_gh_t gh,
		input asid_t asid);
		logic [IDX_BITS-1:0] idx;
		ibtb_hashed_t h;
		idx = pc[IDX_BITS-1:0] ^ IDX_BITS'(gh) ^ IDX_BITS'(asid);
		h.index = MAX_INDEX_BITS'(idx);
		h.tag = pc[IDX_BITS +: TAG_BITS] ^ TAG_BITS'(asid) ^ TAG_BITS'(gh);
		return h;
	endfunction

	ibtb_hashed_t rd_hash;
	ibtb_hashed_t wr_hash;

	assign rd_hash = hash_addr(lookup_q.src_pc, lookup_q.gh, lookup_q.asid);
	assign wr_hash = hash_addr(update_q.src_pc, update_q.gh, update_q.asid);

	// read request out
	assign rd_index = rd_hash.index[IDX_BITS-1:0];
	assign rd_tag = rd_hash.tag;
	// kept for the fall-through target
	assign rd_src_pc = lookup_q.src_pc;

	// write request out, entry always lands valid
	assign wr_en = update_q.valid;
	assign wr_index = wr_hash.index[IDX_BITS-1:0];
	assign wr_entry = '{valid: 1'b1, tag: wr_hash.tag, tgt_pc: update_q.tgt_pc};

	// a stray X on the update valid would corrupt a random set
	a_wr_en_known: assert property (@(posedge CLK) disable iff (!nRST)
		!$isunknown(wr_en));

endmodule

//--- design/ibtb_array.sv
`timescale 1ns/1ps

module ibtb_array
	import ibtb_pkg::*;
#(
	parameter int SETS = 64,
	localparam int IDX_BITS = $clog2(SETS)
) (
	input logic CLK,
	input logic nRST,

	// combinational read port
	input logic [IDX_BITS-1:0] rd_index,

	// registered write port
	input logic wr_en,
	input logic [IDX_BITS-1:0] wr_index,
	input ibtb_entry_t wr_entry,

	output ibtb_entry_t rd_entry
);

	// ------------------------------------------------------------
	// storage

	// valid bits, one per set, cleared on reset
	logic [SETS-1:0] valid_q;

	// tag and target payload per set
	ibtb_entry_t mem_q [SETS];

	// ------------------------------------------------------------
	// write port

	// valid vector
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
		end else if (wr_en) begin
			// update replaces whatever the set held
			valid_q[wr_index] <= wr_entry.valid;
		end
	end

	// payload, written on the same edge as valid
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem_q[wr_index] <= wr_entry;
		end
	end

	// ------------------------------------------------------------
	// read port

	// plain mux off the flops
	// a write this edge is not seen until after the edge
	always_comb begin
		rd_entry = mem_q[rd_index];
		// payload valid field is stale after reset, use the vector
		rd_entry.valid = valid_q[rd_index];
	end

	// ------------------------------------------------------------
	// checks

	// index comes through the hash from the update register
	a_wr_index_known: assert property (@(posedge CLK) disable iff (!nRST)
		wr_en |-> !$isunknown(wr_index));

endmodule

//--- design/ibtb_resolve.sv
`timescale 1ns/1ps

module ibtb_resolve
	import core_pkg::*, ibtb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// entry read for the registered lookup
	input ibtb_entry_t rd_entry,

	// lookup side, from the hash stage
	input ibtb_tag_t rd_tag,
	input pc38_t rd_src_pc,

	output ibtb_result_t result
);

	// ------------------------------------------------------------
	// hit resolution

	logic tag_match;
	logic hit;
	pc38_t fall_through;
	pc38_t tgt;

	// direct-mapped, so a single compare
	assign tag_match = (rd_entry.tag == rd_tag);
	assign hit = rd_entry.valid & tag_match;

	// next sequential word, wraps at 38 bits
	assign fall_through = rd_src_pc + pc38_t'(1);

	// miss falls through
	assign tgt = hit ? rd_entry.tgt_pc : fall_through;

	// ------------------------------------------------------------
	// result register

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			result <= '0;
		end else begin
			result.hit <= hit;
			result.tgt_pc <= tgt;
		end
	end

	// whole pipe from request register through array must be defined
	a_result_known: assert property (@(posedge CLK) disable iff (!nRST)
		!$isunknown(result));

endmodule

//--- design/ibtb_top.sv
`timescale 1ns/1ps

module ibtb_top
	import core_pkg::*, ibtb_pkg::*;
#(
	parameter int SETS = 64,
	localparam int IDX_BITS = $clog2(SETS)
) (
	input logic CLK,
	input logic nRST,

	// fetch side
	input ibtb_lookup_t lookup,
	input ibtb_update_t update,

	output ibtb_result_t result
);

	// ------------------------------------------------------------
	// stage wires

	// hash to array, read
	logic [IDX_BITS-1:0] rd_index;

	// hash to array, write
	logic wr_en;
	logic [IDX_BITS-1:0] wr_index;
	ibtb_entry_t wr_entry;

	// hash to resolve
	ibtb_tag_t rd_tag;
	pc38_t rd_src_pc;

	// array to resolve
	ibtb_entry_t rd_entry;

	// ------------------------------------------------------------
	// stages

	// input side, request registers and hash
	ibtb_hash #(
		.SETS(SETS)
	) u_hash (
		.CLK(CLK),
		.nRST(nRST),
		.lookup(lookup),
		.update(update),
		.rd_index(rd_index),
		.rd_tag(rd_tag),
		.rd_src_pc(rd_src_pc),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_entry(wr_entry)
	);

	// entry storage
	ibtb_array #(
		.SETS(SETS)
	) u_array (
		.CLK(CLK),
		.nRST(nRST),
		.rd_index(rd_index),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_entry(wr_entry),
		.rd_entry(rd_entry)
	);

	// output side, compare and result register
	ibtb_resolve u_resolve (
		.CLK(CLK),
		.nRST(nRST),
		.rd_entry(rd_entry),
		.rd_tag(rd_tag),
		.rd_src_pc(rd_src_pc),
		.result(result)
	);

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic CLK,
	output logic nRST
);

	// free running clock
	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// reset low for RESET_CYCLES rising edges
	// released on a falling edge, away from sampling
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
	end

endmodule

//--- bench/tb_ibtb.sv
`timescale 1ns/1ps

module tb_ibtb
	import core_pkg::*, ibtb_pkg::*;
();

	localparam int SETS = 64;
	localparam int IDX_BITS = $clog2(SETS);
	localparam int PERIOD_NS = 10;
	localparam int RESET_CYCLES = 16;

	// test lengths in items
	localparam int N_MISS = 40;
	localparam int N_TRAIN = 24;
	localparam int N_REPLACE = 12;
	localparam int N_RANDOM = 2000;

	// cycles per item follow the task bodies below
	localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + N_MISS + 5 * N_TRAIN
		+ 7 * N_REPLACE + N_RANDOM + 4;
	localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * PERIOD_NS;

	// lookup plus what the model predicts for it
	typedef struct packed {
		ibtb_lookup_t lk;
		ibtb_result_t exp;
	} expect_t;

	logic CLK;
	logic nRST;
	ibtb_lookup_t lookup;
	ibtb_update_t update;
	ibtb_result_t result;

	// reference state
	ibtb_entry_t model_mem [SETS];
	ibtb_update_t pend_upd;
	expect_t exp_q [$];

	int n_errors;
	int n_checks;
	int n_hits;

	tb_clkgen #(
		.PERIOD_NS(PERIOD_NS),
		.RESET_CYCLES(RESET_CYCLES)
	) u_clkgen (
		.CLK(CLK),
		.nRST(nRST)
	);

	ibtb_top #(
		.SETS(SETS)
	) u_dut (
		.CLK(CLK),
		.nRST(nRST),
		.lookup(lookup),
		.update(update),
		.result(result)
	);

	// ------------------------------------------------------------
	// reference model

	// set index is pc ^ history ^ asid masked to the set count
	function automatic int ref_index(input pc38_t pc, input ibtb_gh_t gh, input asid_t asid);
		logic [63:0] mix;
		mix = 64'(pc) ^ 64'(gh) ^ 64'(asid);
		return int'(mix & 64'(SETS - 1));
	endfunction

	// tag is pc shifted past the index ^ asid ^ history
	function automatic ibtb_tag_t ref_tag(input pc38_t pc, input ibtb_gh_t gh, input asid_t asid);
		logic [63:0] mix;
		mix = (64'(pc) >> IDX_BITS) ^ 64'(asid) ^ 64'(gh);
		return ibtb_tag_t'(mix);
	endfunction

	// expected result of one lookup against the model contents
	function automatic ibtb_result_t ref_predict(input ibtb_lookup_t lk,
		input ibtb_entry_t mem [SETS]);
		ibtb_entry_t e;
		ibtb_result_t r;
		e = mem[ref_index(lk.src_pc, lk.gh, lk.asid)];
		if (e.valid && e.tag == ref_tag(lk.src_pc, lk.gh, lk.asid)) begin
			r.hit = 1'b1;
			r.tgt_pc = e.tgt_pc;
		end else begin
			r.hit = 1'b0;
			r.tgt_pc = lk.src_pc + 38'd1;
		end
		return r;
	endfunction

	// each edge lands the update taken last edge, predicts, then takes this update
	always @(posedge CLK) begin
		expect_t item;
		if (!nRST) begin
			for (int i = 0; i < SETS; i++) begin
				model_mem[i] = '0;
			end
			pend_upd = '0;
		end else begin
			if (pend_upd.valid) begin
				model_mem[ref_index(pend_upd.src_pc, pend_upd.gh, pend_upd.asid)] = '{
					valid: 1'b1,
					tag: ref_tag(pend_upd.src_pc, pend_upd.gh, pend_upd.asid),
					tgt_pc: pend_upd.tgt_pc
				};
			end
			item.lk = lookup;
			item.exp = ref_predict(lookup, model_mem);
			exp_q.push_back(item);
			pend_upd = update;
		end
	end

	// ------------------------------------------------------------
	// comparison

	// head is one edge older than the newest entry, so its result is out now
	always @(negedge CLK) begin
		expect_t head;
		if (nRST && exp_q.size() >= 2) begin
			head = exp_q.pop_front();
			n_checks++;
			if (head.exp.hit) begin
				n_hits++;
			end
			if (result !== head.exp) begin
				n_errors++;
				$display("ERR %0t: pc=%h gh=%h asid=%h exp hit=%0d tgt=%h got hit=%0d tgt=%h",
					$time, head.lk.src_pc, head.lk.gh, head.lk.asid,
					head.exp.hit, head.exp.tgt_pc, result.hit, result.tgt_pc);
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus helpers

	function automatic pc38_t rand_pc();
		return pc38_t'({$urandom(), $urandom()});
	endfunction

	function automatic ibtb_lookup_t make_lookup(input pc38_t pc, input ibtb_gh_t gh,
		input asid_t asid);
		ibtb_lookup_t lk;
		lk.src_pc = pc;
		lk.gh = gh;
		lk.asid = asid;
		return lk;
	endfunction

	function automatic ibtb_update_t make_update(input ibtb_lookup_t lk, input pc38_t tgt);
		ibtb_update_t up;
		up.valid = 1'b1;
		up.src_pc = lk.src_pc;
		up.gh = lk.gh;
		up.asid = lk.asid;
		up.tgt_pc = tgt;
		return up;
	endfunction

	function automatic ibtb_lookup_t rand_lookup();
		return make_lookup(rand_pc(), ibtb_gh_t'($urandom()), asid_t'($urandom()));
	endfunction

	// one cycle of inputs driven after the edge
	task automatic drive(input ibtb_lookup_t lk, input ibtb_update_t up);
		@(posedge CLK);
		lookup <= lk;
		update <= up;
	endtask

	// train then wait out the write latency and probe the key and two neighbors
	task automatic train_then_probe();
		ibtb_lookup_t key;
		key = rand_lookup();
		drive(rand_lookup(), make_update(key, rand_pc()));
		drive(rand_lookup(), '0);
		drive(key, '0);
		// same pc and history under another asid
		drive(make_lookup(key.src_pc, key.gh, key.asid ^ asid_t'(1 + $urandom_range(0, 510))),
			'0);
		// history alone moved
		drive(make_lookup(key.src_pc, key.gh ^ ibtb_gh_t'(1 + $urandom_range(0, 254)), key.asid),
			'0);
	endtask

	// second update to the same set
	// a lookup in the cycle of that update still sees the old entry
	task automatic replace_same_set();
		ibtb_lookup_t key_a;
		ibtb_lookup_t key_b;
		key_a = rand_lookup();
		// flip the bit just above the index for the same set and a new tag
		key_b = key_a;
		key_b.src_pc = key_a.src_pc ^ (38'd1 << IDX_BITS);
		drive(rand_lookup(), make_update(key_a, rand_pc()));
		drive(rand_lookup(), '0);
		drive(key_a, make_update(key_b, rand_pc()));
		drive(key_a, '0);
		drive(key_a, '0);
		drive(key_b, '0);
		drive(rand_lookup(), '0);
	endtask

	// small pools force set conflicts
	task automatic random_mix();
		pc38_t pc_pool [8];
		ibtb_gh_t gh_pool [4];
		asid_t asid_pool [2];
		ibtb_lookup_t lk;
		ibtb_lookup_t uk;
		ibtb_update_t up;
		foreach (pc_pool[i]) pc_pool[i] = rand_pc();
		foreach (gh_pool[i]) gh_pool[i] = ibtb_gh_t'($urandom());
		foreach (asid_pool[i]) asid_pool[i] = asid_t'($urandom());
		for (int n = 0; n < N_RANDOM; n++) begin
			lk = make_lookup(pc_pool[$urandom_range(0, 7)], gh_pool[$urandom_range(0, 3)],
				asid_pool[$urandom_range(0, 1)]);
			uk = make_lookup(pc_pool[$urandom_range(0, 7)], gh_pool[$urandom_range(0, 3)],
				asid_pool[$urandom_range(0, 1)]);
			up = '0;
			if ($urandom_range(0, 1) == 1) begin
				up = make_update(uk, rand_pc());
			end
			drive(lk, up);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence

	initial begin
		int unsigned seed;
		seed = 32'hd7b6e05d;
		void'($urandom(seed));
		lookup = '0;
		update = '0;
		n_errors = 0;
		n_checks = 0;
		n_hits = 0;
		wait (nRST === 1'b1);

		// every lookup falls through on an empty buffer
		repeat (N_MISS) drive(rand_lookup(), '0);
		repeat (N_TRAIN) train_then_probe();
		repeat (N_REPLACE) replace_same_set();
		random_mix();
		// drain the two stage pipe
		repeat (4) drive(rand_lookup(), '0);

		if (n_hits == 0) begin
			n_errors++;
			$display("no lookup was expected to hit, training was not exercised");
		end
		$display("checks: %0d, expected hits: %0d, errors: %0d", n_checks, n_hits, n_errors);
		if (n_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// ------------------------------------------------------------
	// watchdog

	initial begin
		#(WATCHDOG_NS * 1ns);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- sim.f
design/core_pkg.sv
design/ibtb_pkg.sv
design/ibtb_hash.sv
design/ibtb_array.sv
design/ibtb_resolve.sv
design/ibtb_top.sv
bench/tb_clkgen.sv
bench/tb_ibtb.sv

//--- Makefile
# Verilator build and run for the IBTB testbench

VERILATOR ?= verilator
TOP       ?= tb_ibtb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= NO ERRORS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the pass message stands on a line of its own
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
